/* rtl/board_ctrl_if.sv */
interface board_ctrl_if;

    logic soft_rst;     // One-cycle pulse from the reset hotkey
    logic dip_flip;     // Screen flip setting, a change restarts the game
    logic rot_control;  // Swap directions for rotated screens
    logic game_pause;   // Pause toggle state
    logic joy_pause;    // Either player's pause button

    modport reset_mp (
        input soft_rst,
        input dip_flip
    );

    modport joy_mp (
        input  rot_control,
        output joy_pause
    );

    modport hotkey_mp (
        input  joy_pause,
        output soft_rst,
        output game_pause
    );

    modport dip_mp (
        input  game_pause,
        output dip_flip,
        output rot_control
    );

endinterface

/* rtl/board_pkg.sv */
package board_pkg;

    localparam int JOY_W      = 16;  // Board joystick word
    localparam int GAME_JOY_W = 10;  // Joystick word seen by the game
    localparam int STATUS_W   = 32;  // OSD status word
    localparam int GFX_LAYERS = 4;

    // Two-button layout, one bit per direction in the low nibble
    typedef struct packed {
        logic [5:0] unused;
        logic       pause;
        logic       coin;
        logic       start2;
        logic       start1;
        logic [1:0] buttons;
        logic       up;
        logic       down;
        logic       left;
        logic       right;
    } joy_two_t;

    // Three-button layout shifts the control bits up by one
    typedef struct packed {
        logic [4:0] unused;
        logic       pause;
        logic       coin;
        logic       start2;
        logic       start1;
        logic [2:0] buttons;
        logic       up;
        logic       down;
        logic       left;
        logic       right;
    } joy_three_t;

    typedef union packed {
        joy_two_t   two;
        joy_three_t three;
    } joy_word_u;

    localparam logic [7:0] ASPECT_NARROW_X = 8'd4;
    localparam logic [7:0] ASPECT_NARROW_Y = 8'd3;
    localparam logic [7:0] ASPECT_WIDE_X   = 8'd16;
    localparam logic [7:0] ASPECT_WIDE_Y   = 8'd9;

    // Status word bit positions
    localparam int ST_WIDE      = 1;
    localparam int ST_NO_ROTATE = 2;
    localparam int ST_ROT_CTRL  = 3;
    localparam int ST_FM_OFF    = 6;
    localparam int ST_PSG_OFF   = 7;
    localparam int ST_FX_LO     = 8;   // Effect level spans bits 9:8
    localparam int ST_TEST      = 10;
    localparam int ST_PAUSE     = 11;
    localparam int ST_FLIP      = 12;

endpackage

/* rtl/board_top.sv */
module board_top #(
    parameter bit THREE_BUTTONS = 1'b0,
    parameter bit ACTIVE_LOW    = 1'b1,
    parameter int RST_CNT_W     = 8
) (
    input  logic                             clk_sys,
    input  logic                             rst,
    input  logic                             rst_req,
    input  logic                             downloading,
    input  logic [board_pkg::JOY_W-1:0]      board_joystick1,
    input  logic [board_pkg::JOY_W-1:0]      board_joystick2,
    input  logic                             key_pause,
    input  logic                             key_reset,
    input  logic                             key_service,
    input  logic [board_pkg::GFX_LAYERS-1:0] key_gfx,
    input  logic [board_pkg::GFX_LAYERS-1:0] key_vgactrl,
    input  logic [board_pkg::STATUS_W-1:0]   status,
    output logic                             sys_rst_n,
    output logic                             game_rst,
    output logic                             game_rst_n,
    output logic [board_pkg::GAME_JOY_W-1:0] game_joystick1,
    output logic [board_pkg::GAME_JOY_W-1:0] game_joystick2,
    output logic [1:0]                       game_coin,
    output logic [1:0]                       game_start,
    output logic                             game_service,
    output logic [board_pkg::GFX_LAYERS-1:0] gfx_en,
    output logic [board_pkg::GFX_LAYERS-1:0] vgactrl_en,
    output logic [7:0]                       hdmi_arx,
    output logic [7:0]                       hdmi_ary,
    output logic [1:0]                       rotate,
    output logic                             enable_fm,
    output logic                             enable_psg,
    output logic                             dip_test,
    output logic                             dip_pause,
    output logic                             dip_flip,
    output logic [1:0]                       dip_fxlevel
);

    board_ctrl_if ctrl_bus ();

    reset_ctrl #(
        .RST_CNT_W (RST_CNT_W)
    ) u_reset (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .rst_req     (rst_req),
        .downloading (downloading),
        .ctrl        (ctrl_bus),
        .sys_rst_n   (sys_rst_n),
        .game_rst    (game_rst),
        .game_rst_n  (game_rst_n)
    );

    joy_mapper #(
        .THREE_BUTTONS (THREE_BUTTONS),
        .ACTIVE_LOW    (ACTIVE_LOW)
    ) u_joy (
        .clk_sys         (clk_sys),
        .rst             (rst),
        .board_joystick1 (board_joystick1),
        .board_joystick2 (board_joystick2),
        .ctrl            (ctrl_bus),
        .game_joystick1  (game_joystick1),
        .game_joystick2  (game_joystick2),
        .game_coin       (game_coin),
        .game_start      (game_start)
    );

    hotkey_ctrl #(
        .ACTIVE_LOW (ACTIVE_LOW)
    ) u_hotkey (
        .clk_sys      (clk_sys),
        .rst          (rst),
        .key_pause    (key_pause),
        .key_reset    (key_reset),
        .key_service  (key_service),
        .key_gfx      (key_gfx),
        .key_vgactrl  (key_vgactrl),
        .ctrl         (ctrl_bus),
        .game_service (game_service),
        .gfx_en       (gfx_en),
        .vgactrl_en   (vgactrl_en)
    );

    dip_decode u_dip (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .status      (status),
        .ctrl        (ctrl_bus),
        .hdmi_arx    (hdmi_arx),
        .hdmi_ary    (hdmi_ary),
        .rotate      (rotate),
        .enable_fm   (enable_fm),
        .enable_psg  (enable_psg),
        .dip_test    (dip_test),
        .dip_pause   (dip_pause),
        .dip_fxlevel (dip_fxlevel)
    );

    assign dip_flip = ctrl_bus.dip_flip;  // Game side needs it too

endmodule

/* rtl/dip_decode.sv */
module dip_decode (
    input  logic                           clk_sys,
    input  logic                           rst,
    input  logic [board_pkg::STATUS_W-1:0] status,
    board_ctrl_if.dip_mp                   ctrl,
    output logic [7:0]                     hdmi_arx,
    output logic [7:0]                     hdmi_ary,
    output logic [1:0]                     rotate,
    output logic                           enable_fm,
    output logic                           enable_psg,
    output logic                           dip_test,
    output logic                           dip_pause,
    output logic [1:0]                     dip_fxlevel
);

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            // Same as an all-zero status word
            hdmi_arx         <= board_pkg::ASPECT_NARROW_X;
            hdmi_ary         <= board_pkg::ASPECT_NARROW_Y;
            rotate           <= 2'b00;
            ctrl.rot_control <= 1'b0;
            ctrl.dip_flip    <= 1'b0;
            enable_fm        <= 1'b1;
            enable_psg       <= 1'b1;
            dip_test         <= 1'b1;
            dip_pause        <= 1'b1;
            dip_fxlevel      <= 2'b00;
        end else begin
            if (status[board_pkg::ST_WIDE]) begin
                hdmi_arx <= board_pkg::ASPECT_WIDE_X;
                hdmi_ary <= board_pkg::ASPECT_WIDE_Y;
            end else begin
                hdmi_arx <= board_pkg::ASPECT_NARROW_X;
                hdmi_ary <= board_pkg::ASPECT_NARROW_Y;
            end
            rotate           <= {status[board_pkg::ST_FLIP], status[board_pkg::ST_NO_ROTATE]};
            ctrl.rot_control <= status[board_pkg::ST_ROT_CTRL];
            ctrl.dip_flip    <= status[board_pkg::ST_FLIP];
            enable_fm        <= ~status[board_pkg::ST_FM_OFF];
            enable_psg       <= ~status[board_pkg::ST_PSG_OFF];
            dip_test         <= ~status[board_pkg::ST_TEST];  // Active low
            // Hotkey toggle or menu setting, either one stops the game
            dip_pause        <= ~(ctrl.game_pause | status[board_pkg::ST_PAUSE]);
            dip_fxlevel      <= status[board_pkg::ST_FX_LO+1 -: 2];
        end
    end

endmodule

/* rtl/hotkey_ctrl.sv */
module hotkey_ctrl #(
    parameter bit ACTIVE_LOW = 1'b1
) (
    input  logic                             clk_sys,
    input  logic                             rst,
    input  logic                             key_pause,
    input  logic                             key_reset,
    input  logic                             key_service,
    input  logic [board_pkg::GFX_LAYERS-1:0] key_gfx,
    input  logic [board_pkg::GFX_LAYERS-1:0] key_vgactrl,
    board_ctrl_if.hotkey_mp                  ctrl,
    output logic                             game_service,
    output logic [board_pkg::GFX_LAYERS-1:0] gfx_en,
    output logic [board_pkg::GFX_LAYERS-1:0] vgactrl_en
);

    localparam int NL  = board_pkg::GFX_LAYERS;
    localparam int NEN = 2 * NL;  // Layer enables, then video-control enables

    logic           last_pause;
    logic           last_reset;
    logic           last_joypause;
    logic [NEN-1:0] last_en_keys;
    logic [NEN-1:0] en_keys;
    logic [NEN-1:0] en_rise;
    logic [NEN-1:0] en_state;
    logic           pause_rise;
    logic           pause_q;
    logic           soft_rst_q;

    assign en_keys = {key_vgactrl, key_gfx};

    // Previous key levels for edge detection
    always_ff @(posedge clk_sys) begin
        last_pause    <= key_pause;
        last_reset    <= key_reset;
        last_joypause <= ctrl.joy_pause;
        last_en_keys  <= en_keys;
    end

    assign en_rise    = en_keys & ~last_en_keys;
    assign pause_rise = (key_pause & ~last_pause)
                      | (ctrl.joy_pause & ~last_joypause);

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            pause_q      <= 1'b0;
            soft_rst_q   <= 1'b0;
            en_state     <= '1;          // Everything visible
            game_service <= ACTIVE_LOW;
        end else begin
            soft_rst_q <= key_reset & ~last_reset;
            if (pause_rise)
                pause_q <= ~pause_q;
            en_state     <= en_state ^ en_rise;  // Flip only the pressed bits
            game_service <= key_service ^ ACTIVE_LOW;
        end
    end

    assign gfx_en          = en_state[NL-1:0];
    assign vgactrl_en      = en_state[NEN-1:NL];
    assign ctrl.game_pause = pause_q;
    assign ctrl.soft_rst   = soft_rst_q;

endmodule

/* rtl/joy_mapper.sv */
module joy_mapper #(
    parameter bit THREE_BUTTONS = 1'b0,
    parameter bit ACTIVE_LOW    = 1'b1
) (
    input  logic                             clk_sys,
    input  logic                             rst,
    input  logic [board_pkg::JOY_W-1:0]      board_joystick1,
    input  logic [board_pkg::JOY_W-1:0]      board_joystick2,
    board_ctrl_if.joy_mp                     ctrl,
    output logic [board_pkg::GAME_JOY_W-1:0] game_joystick1,
    output logic [board_pkg::GAME_JOY_W-1:0] game_joystick2,
    output logic [1:0]                       game_coin,
    output logic [1:0]                       game_start
);

    localparam int GW = board_pkg::GAME_JOY_W;

    // Positions inside the extracted control nibble
    localparam int CTL_START1 = 0;
    localparam int CTL_START2 = 1;
    localparam int CTL_COIN   = 2;
    localparam int CTL_PAUSE  = 3;

    board_pkg::joy_word_u joy1_sync;
    board_pkg::joy_word_u joy2_sync;
    logic [3:0]           p1_ctl;
    logic [3:0]           p2_ctl;

    // Same board word, read through the layout the game uses
    function automatic logic [3:0] ctl_bits(input board_pkg::joy_word_u w);
        if (THREE_BUTTONS)
            return {w.three.pause, w.three.coin, w.three.start2, w.three.start1};
        return {w.two.pause, w.two.coin, w.two.start2, w.two.start1};
    endfunction

    function automatic logic [GW-1:0] apply_rotation(input logic [GW-1:0] j,
                                                     input logic          rot);
        logic [GW-1:0] r;
        r = j;
        if (rot) begin
            r[1:0] = {j[0], j[1]};  // Right and left swap
            r[3:2] = {j[2], j[3]};  // Down and up swap
        end
        return r;
    endfunction

    always_ff @(posedge clk_sys) begin
        joy1_sync <= board_joystick1;
        joy2_sync <= board_joystick2;
    end

    assign p1_ctl = ctl_bits(joy1_sync);
    assign p2_ctl = ctl_bits(joy2_sync);

    assign ctrl.joy_pause = p1_ctl[CTL_PAUSE] | p2_ctl[CTL_PAUSE];

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_joystick1 <= {GW{ACTIVE_LOW}};  // All released
            game_joystick2 <= {GW{ACTIVE_LOW}};
            game_coin      <= {2{ACTIVE_LOW}};
            game_start     <= {2{ACTIVE_LOW}};
        end else begin
            game_joystick1 <= {GW{ACTIVE_LOW}}
                            ^ apply_rotation(joy1_sync[GW-1:0], ctrl.rot_control);
            game_joystick2 <= {GW{ACTIVE_LOW}}
                            ^ apply_rotation(joy2_sync[GW-1:0], ctrl.rot_control);
            game_coin      <= {2{ACTIVE_LOW}} ^ {p2_ctl[CTL_COIN], p1_ctl[CTL_COIN]};
            // Either player may press either start
            game_start     <= {2{ACTIVE_LOW}}
                            ^ {p1_ctl[CTL_START2] | p2_ctl[CTL_START2],
                               p1_ctl[CTL_START1] | p2_ctl[CTL_START1]};
        end
    end

endmodule

/* rtl/reset_ctrl.sv */
module reset_ctrl #(
    parameter int RST_CNT_W = 8
) (
    input  logic            clk_sys,
    input  logic            rst,
    input  logic            rst_req,
    input  logic            downloading,
    board_ctrl_if.reset_mp  ctrl,
    output logic            sys_rst_n,
    output logic            game_rst,
    output logic            game_rst_n
);

    localparam logic [RST_CNT_W-1:0] CNT_MAX = '1;

    logic                 last_dip_flip;
    logic                 trigger;
    logic [RST_CNT_W-1:0] rst_cnt;

    // Release chains, index 0 for the system reset and 1 for the game reset
    logic [1:0] hold;
    logic [1:0] pre_rel_n;
    logic [1:0] rel_n;

    always_ff @(posedge clk_sys) begin
        last_dip_flip <= ctrl.dip_flip;
    end

    // Flipping the screen restarts the game as well
    assign trigger = rst | downloading | rst_req | ctrl.soft_rst
                   | (ctrl.dip_flip != last_dip_flip);

    // Every trigger restarts the stretch from zero
    always_ff @(posedge clk_sys) begin
        if (trigger) begin
            rst_cnt  <= '0;
            game_rst <= 1'b1;
        end else if (rst_cnt != CNT_MAX) begin
            rst_cnt  <= rst_cnt + 1'b1;
            game_rst <= 1'b1;
        end else begin
            game_rst <= 1'b0;  // Counter saturated
        end
    end

    assign hold = {game_rst, rst | downloading};

    // Assert at once, release two edges after the hold drops
    always_ff @(posedge clk_sys) begin
        for (int i = 0; i < 2; i++) begin
            if (hold[i]) begin
                pre_rel_n[i] <= 1'b0;
                rel_n[i]     <= 1'b0;
            end else begin
                pre_rel_n[i] <= 1'b1;
                rel_n[i]     <= pre_rel_n[i];
            end
        end
    end

    assign sys_rst_n  = rel_n[0];
    assign game_rst_n = rel_n[1];

endmodule

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sources.f --top-module tb_board -o sim_board

# The run may end with a nonzero status, the log decides
./obj_dir/sim_board +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
    echo "Simulation did not complete"
    exit 1
fi
echo "Simulation passed"

/* sim/board_props.sv */
module board_props #(
    parameter int RST_CNT_W  = 8,
    parameter bit ACTIVE_LOW = 1'b1
) (
    input logic        clk_sys,
    input logic        rst,
    input logic        rst_req,
    input logic        downloading,
    input logic [15:0] board_joystick1,
    input logic [15:0] board_joystick2,
    input logic        key_pause,
    input logic        key_reset,
    input logic        key_service,
    input logic [3:0]  key_gfx,
    input logic [3:0]  key_vgactrl,
    input logic [31:0] status,
    input logic        sys_rst_n,
    input logic        game_rst,
    input logic        game_rst_n,
    input logic [9:0]  game_joystick1,
    input logic [9:0]  game_joystick2,
    input logic [1:0]  game_coin,
    input logic [1:0]  game_start,
    input logic        game_service,
    input logic [3:0]  gfx_en,
    input logic [3:0]  vgactrl_en,
    input logic [7:0]  hdmi_arx,
    input logic [7:0]  hdmi_ary,
    input logic [1:0]  rotate,
    input logic        enable_fm,
    input logic        enable_psg,
    input logic        dip_test,
    input logic        dip_pause,
    input logic        dip_flip,
    input logic [1:0]  dip_fxlevel
);

    localparam int LEN = 1 << RST_CNT_W;

    int                 fail_cnt = 0;  // Failed assertions so far
    logic [2:0]         up_cnt;
    logic               ready;
    logic               key_pause_d;
    logic               jp_d1;
    logic               jp_d2;
    logic               pause_model;
    logic [7:0]         en_keys_d;
    logic [7:0]         en_model;
    logic               key_reset_d;
    logic               soft_pulse;
    logic               flip_d;
    logic               trig;
    logic [RST_CNT_W:0] since;
    logic               rst_model;

    // Expected game word in the two-button layout
    function automatic logic [9:0] game_view(input logic [15:0] w, input logic rot);
        logic [9:0] g;
        g = w[9:0];
        if (rot)
            g[3:0] = {w[2], w[3], w[0], w[1]};
        return g ^ {10{ACTIVE_LOW}};
    endfunction

    // Coins per player, starts merged across both players
    function automatic logic [3:0] coin_start(input logic [15:0] j1, input logic [15:0] j2);
        return {j2[8], j1[8], j1[7] | j2[7], j1[6] | j2[6]} ^ {4{ACTIVE_LOW}};
    endfunction

    // Aspect, rotate, sound, test, effect level and flip from one status word
    function automatic logic [23:0] settings(input logic [31:0] s);
        logic [15:0] ar;
        ar = s[1] ? {8'd16, 8'd9} : {8'd4, 8'd3};
        return {ar, s[12], s[2], ~s[6], ~s[7], ~s[10], s[9:8], s[12]};
    endfunction

    always_ff @(posedge clk_sys) begin
        if (rst)
            up_cnt <= '0;
        else if (up_cnt != 3'd7)
            up_cnt <= up_cnt + 1'b1;
    end
    assign ready = (up_cnt == 3'd7);

    always_ff @(posedge clk_sys) begin
        key_pause_d <= key_pause;
        jp_d1       <= board_joystick1[9] | board_joystick2[9];
        jp_d2       <= jp_d1;
        en_keys_d   <= {key_vgactrl, key_gfx};
        key_reset_d <= key_reset;
        flip_d      <= dip_flip;
        if (rst) begin
            pause_model <= 1'b0;
            soft_pulse  <= 1'b0;
            en_model    <= '1;
        end else begin
            soft_pulse <= key_reset & ~key_reset_d;
            if ((key_pause & ~key_pause_d) | (jp_d1 & ~jp_d2))
                pause_model <= ~pause_model;
            en_model <= en_model ^ ({key_vgactrl, key_gfx} & ~en_keys_d);  // Rising keys
        end
        if (trig)
            since <= '0;
        else if (since != LEN)
            since <= since + 1'b1;
    end

    assign trig      = rst | downloading | rst_req | soft_pulse | (dip_flip != flip_d);
    assign rst_model = (since < LEN);

    a_joy1: assert property (@(posedge clk_sys) disable iff (rst) ready |->
        game_joystick1 == game_view($past(board_joystick1, 2), $past(status[3], 2)))
    else begin
        fail_cnt++;
        $error("FAIL joy1 expected %h actual %h",
               game_view($past(board_joystick1, 2), $past(status[3], 2)),
               $sampled(game_joystick1));
    end

    a_joy2: assert property (@(posedge clk_sys) disable iff (rst) ready |->
        game_joystick2 == game_view($past(board_joystick2, 2), $past(status[3], 2)))
    else begin
        fail_cnt++;
        $error("FAIL joy2 expected %h actual %h",
               game_view($past(board_joystick2, 2), $past(status[3], 2)),
               $sampled(game_joystick2));
    end

    a_coin_start: assert property (@(posedge clk_sys) disable iff (rst) ready |->
        {game_coin, game_start}
        == coin_start($past(board_joystick1, 2), $past(board_joystick2, 2)))
    else begin
        fail_cnt++;
        $error("FAIL coin_start expected %b actual %b",
               coin_start($past(board_joystick1, 2), $past(board_joystick2, 2)),
               $sampled({game_coin, game_start}));
    end

    a_toggles: assert property (@(posedge clk_sys) disable iff (rst) ready |->
        {vgactrl_en, gfx_en} == en_model)
    else begin
        fail_cnt++;
        $error("FAIL toggles expected %b actual %b",
               $sampled(en_model), $sampled({vgactrl_en, gfx_en}));
    end

    a_service: assert property (@(posedge clk_sys) disable iff (rst) ready |->
        game_service == ($past(key_service) ^ ACTIVE_LOW))
    else begin
        fail_cnt++;
        $error("FAIL service expected %b actual %b",
               $past(key_service) ^ ACTIVE_LOW, $sampled(game_service));
    end

    a_pause: assert property (@(posedge clk_sys) disable iff (rst) ready |->
        dip_pause == !($past(pause_model) | $past(status[11])))
    else begin
        fail_cnt++;
        $error("FAIL pause expected %b actual %b",
               !($past(pause_model) | $past(status[11])), $sampled(dip_pause));
    end

    a_game_rst: assert property (@(posedge clk_sys) disable iff (rst) ready |->
        game_rst == rst_model)
    else begin
        fail_cnt++;
        $error("FAIL game_rst expected %b actual %b",
               $sampled(rst_model), $sampled(game_rst));
    end

    a_game_rst_n: assert property (@(posedge clk_sys) disable iff (rst) ready |->
        game_rst_n == !($past(rst_model) | $past(rst_model, 2)))
    else begin
        fail_cnt++;
        $error("FAIL game_rst_n expected %b actual %b",
               !($past(rst_model) | $past(rst_model, 2)), $sampled(game_rst_n));
    end

    a_sys_rst_n: assert property (@(posedge clk_sys) disable iff (rst) ready |->
        sys_rst_n == !($past(downloading) | $past(downloading, 2)))
    else begin
        fail_cnt++;
        $error("FAIL sys_rst_n expected %b actual %b",
               !($past(downloading) | $past(downloading, 2)), $sampled(sys_rst_n));
    end

    a_settings: assert property (@(posedge clk_sys) disable iff (rst) ready |->
        {hdmi_arx, hdmi_ary, rotate, enable_fm, enable_psg, dip_test, dip_fxlevel, dip_flip}
        == settings($past(status)))
    else begin
        fail_cnt++;
        $error("FAIL settings expected %h actual %h",
               settings($past(status)),
               $sampled({hdmi_arx, hdmi_ary, rotate, enable_fm, enable_psg,
                         dip_test, dip_fxlevel, dip_flip}));
    end

endmodule

bind board_top board_props #(
    .RST_CNT_W  (RST_CNT_W),
    .ACTIVE_LOW (ACTIVE_LOW)
) u_props (.*);

/* sim/tb_board.sv */
module tb_board;

    logic        clk_sys, rst, rst_req, downloading;
    logic [15:0] board_joystick1, board_joystick2;
    logic        key_pause, key_reset, key_service;
    logic [3:0]  key_gfx, key_vgactrl;
    logic [31:0] status;
    logic        sys_rst_n, game_rst, game_rst_n, game_service;
    logic [9:0]  game_joystick1, game_joystick2;
    logic [1:0]  game_coin, game_start, rotate, dip_fxlevel;
    logic [3:0]  gfx_en, vgactrl_en;
    logic [7:0]  hdmi_arx, hdmi_ary;
    logic        enable_fm, enable_psg, dip_test, dip_pause, dip_flip;
    logic [31:0] lfsr = 32'h1ced_c918;

    board_top #(.THREE_BUTTONS(1'b0), .RST_CNT_W(4)) uut (.*);

    initial begin
        clk_sys = 1'b0;
        forever #20 clk_sys = ~clk_sys;
    end

    // One Galois step for each bit taken from lfsr[0]
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
    endtask

    task automatic wait_game_running(input int limit);
        int n;
        n = 0;
        while (game_rst || !game_rst_n) begin
            @(negedge clk_sys);
            n++;
            if (n > limit) begin
                $display("Timeout waiting for the game reset to release");
                $display("ERRORS FOUND");
                $fatal(1, "timeout");
            end
        end
    endtask

    // Random stimulus for one cycle with rare events gated by runs of zero bits
    task automatic drive_cycle();
        logic [31:0] r;
        take_bits(2, r);
        if (r[1:0] == 2'd0) begin
            take_bits(16, r);
            board_joystick1 = r[15:0];
            take_bits(16, r);
            board_joystick2 = r[15:0];
        end
        take_bits(3, r);
        key_pause = (r[2:0] == 3'd0);
        take_bits(6, r);
        key_reset = (r[5:0] == 6'd0);
        take_bits(7, r);
        rst_req = (r[6:0] == 7'd0);
        take_bits(8, r);
        downloading = (r[7:0] == 8'd0);
        take_bits(8, r);
        key_gfx     = r[3:0];
        key_vgactrl = r[7:4];
        take_bits(1, r);
        key_service = r[0];
        take_bits(5, r);
        if (r[4:0] == 5'd0) begin
            take_bits(16, r);
            status = {16'd0, r[15:0]};
        end
    endtask

    always @(posedge clk_sys) begin
        if (uut.u_props.fail_cnt != 0) begin
            $display("ERRORS FOUND");
            $fatal(1, "assertion failed");
        end
    end

    initial begin
        rst = 1'b1;
        rst_req = 1'b0;
        downloading = 1'b0;
        board_joystick1 = '0;
        board_joystick2 = '0;
        key_pause = 1'b0;
        key_reset = 1'b0;
        key_service = 1'b0;
        key_gfx = '0;
        key_vgactrl = '0;
        status = '0;
        repeat (3) @(posedge clk_sys);
        @(negedge clk_sys);
        rst = 1'b0;
        wait_game_running(100);
        for (int c = 0; c < 4000; c++) begin
            @(negedge clk_sys);
            drive_cycle();
        end
        @(negedge clk_sys);
        rst_req = 1'b0;
        downloading = 1'b0;
        key_reset = 1'b0;
        wait_game_running(100);
        repeat (4) @(negedge clk_sys);
        if (uut.u_props.fail_cnt != 0) begin
            $display("ERRORS FOUND");
            $fatal(1, "assertion failed");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

/* sources.f */
rtl/board_pkg.sv
rtl/board_ctrl_if.sv
rtl/reset_ctrl.sv
rtl/joy_mapper.sv
rtl/hotkey_ctrl.sv
rtl/dip_decode.sv
rtl/board_top.sv
sim/board_props.sv
sim/tb_board.sv
